//--- bench/tb_model.svh
`ifndef TB_MODEL_SVH
`define TB_MODEL_SVH

// galois lfsr with the polynomial x^32 + x^22 + x^2 + x + 1.
function automatic logic [31:0] lfsr_next(input logic [31:0] s);
  return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
endfunction

// weight k of ROM row a is the low byte of a*37 + k*11 + 5, taken as signed.
function automatic int model_weight(input int a, input int k);
  logic [7:0] b;
  b = 8'((a * 37 + k * 11 + 5) & 255);
  return int'($signed(b));
endfunction

// a layer sum covers every phase, and each of the four rows of a phase meets the same sample.
function automatic int model_layer_sum(input int layer, input int phases, input logic [71:0] smp);
  int total;
  logic signed [7:0] s;
  total = 0;
  for (int p = 0; p < phases; p++) begin
    for (int r = 0; r < 4; r++) begin
      for (int k = 0; k < 9; k++) begin
        s = smp[k*8 +: 8];
        total += model_weight(layer * 32 + p * 4 + r, k) * int'(s);
      end
    end
  end
  return total;
endfunction

`endif

//--- bench/tb_weight_fetch.sv
`timescale 1ns/1ps

module tb_weight_fetch;

  `include "tb_model.svh"

  localparam int NUM_PHASES = 8;
  localparam int NUM_TRANS = 12;
  localparam int NUM_LAYERS = 5;
  localparam int WAIT_LIMIT = 2000;  // cycles allowed for one handshake wait.
  localparam longint WATCHDOG_NS = (NUM_TRANS * NUM_LAYERS * NUM_PHASES * 12 + 2000) * 40;

  logic clk;
  logic rst_n;
  logic start;
  logic [71:0] sample;
  logic done;
  logic signed [31:0] result;
  logic [2:0] result_layer;
  logic result_valid;
  logic [31:0] lfsr;

  weight_fetch_top #(
    .NUM_PHASES(NUM_PHASES)
  ) i_dut (
    .clk(clk),
    .rst_n(rst_n),
    .start(start),
    .sample(sample),
    .done(done),
    .result(result),
    .result_layer(result_layer),
    .result_valid(result_valid)
  );

  always #20 clk = ~clk;

  task automatic report_failure(input string what);
    $display("%s", what);
    $display("*** TEST FAILED ***");
    $fatal(1, "stopped at the first error");
  endtask

  // the newest bit lands in bit 0.
  task automatic take_bits(input int n, output logic [71:0] bits);
    bits = '0;
    for (int i = 0; i < n; i++) begin
      bits = {bits[70:0], lfsr[0]};
      lfsr = lfsr_next(lfsr);
    end
  endtask

  task automatic idle_cycles(input int n);
    repeat (n) begin
      @(negedge clk);
      assert (done === 1'b0)
        else report_failure($sformatf("CHECK FAILED done: got %h expected 0", done));
      assert (result_valid === 1'b0)
        else report_failure($sformatf("CHECK FAILED result_valid: got %h expected 0", result_valid));
    end
  endtask

  task automatic run_transaction(input logic [71:0] smp);
    int seen;
    int waited;
    int expected;
    logic [71:0] hold;
    seen = 0;
    waited = 0;
    start = 1'b1;
    sample = smp;
    while (done !== 1'b1) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_failure("done never rose after start was raised");
      if (result_valid === 1'b1) begin
        assert (seen < NUM_LAYERS) else report_failure("more than five results in one transaction");
        expected = model_layer_sum(seen, NUM_PHASES, smp);
        assert (result_layer === 3'(seen))
          else report_failure($sformatf("CHECK FAILED result_layer: got %h expected %h",
                                        result_layer, 3'(seen)));
        assert (result === expected)
          else report_failure($sformatf("CHECK FAILED result: got %h expected %h",
                                        result, expected));
        seen++;
      end
    end
    // done and the AFFINE result arrive on the same edge.
    assert (seen == NUM_LAYERS)
      else report_failure($sformatf("done rose after %0d results instead of five", seen));
    take_bits(2, hold);
    repeat (int'(hold[1:0])) begin
      @(negedge clk);
      assert (done === 1'b1)
        else report_failure($sformatf("CHECK FAILED done: got %h expected 1", done));
      assert (result_valid === 1'b0)
        else report_failure($sformatf("CHECK FAILED result_valid: got %h expected 0", result_valid));
    end
    start = 1'b0;
    waited = 0;
    while (done !== 1'b0) begin
      @(negedge clk);
      waited++;
      if (waited > WAIT_LIMIT) report_failure("done never fell after start was released");
    end
    assert (waited == 1)
      else report_failure($sformatf("CHECK FAILED done fall delay: got %h expected 1", waited));
  endtask

  initial begin
    logic [71:0] smp;
    logic [71:0] gap;
    clk = 1'b0;
    rst_n = 1'b0;
    start = 1'b0;
    sample = '0;
    lfsr = 32'he928d378;
    repeat (10) @(negedge clk);
    rst_n = 1'b1;
    idle_cycles(3);
    for (int t = 0; t < NUM_TRANS; t++) begin
      take_bits(72, smp);
      take_bits(3, gap);
      idle_cycles(int'(gap[2:0]));
      run_transaction(smp);
    end
    idle_cycles(2);
    $display("*** TEST PASSED ***");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    report_failure("watchdog expired before all transactions finished");
  end

endmodule

//--- build.f
+incdir+bench
common/nn_pkg.sv
common/weight_fetch_if.sv
weight_store/weight_rom.sv
weight_store/weight_store.sv
logic/phase_counter.sv
logic/layer_sequencer.sv
logic/dot_accumulator.sv
logic/weight_fetch_top.sv
bench/tb_weight_fetch.sv

//--- common/nn_pkg.sv
package nn_pkg;

  localparam int data_len = 8;
  localparam int ROW_VALS = 9;  // values held in one ROM row.
  localparam int ROWS_PER_FETCH = 4;
  localparam int FETCH_VALS = ROW_VALS * ROWS_PER_FETCH;
  localparam int ROWS_PER_LAYER = 32;
  localparam int NUM_LAYERS = 5;

  typedef logic signed [data_len-1:0] val_t;
  typedef val_t [ROW_VALS-1:0] row_t;
  typedef val_t [FETCH_VALS-1:0] wvec_t;
  typedef logic signed [31:0] acc_t;
  typedef logic [2:0] phase_t;
  typedef logic [7:0] rom_addr_t;

  typedef enum logic [2:0] {
    LAYER0 = 3'd0,
    LAYER1 = 3'd1,
    LAYER2 = 3'd2,
    LAYER3 = 3'd3,
    AFFINE = 3'd4
  } layer_t;

  // weight k of row a is the low byte of a*37 + k*11 + 5.
  function automatic row_t rom_row(rom_addr_t a);
    row_t r;
    int v;
    for (int k = 0; k < ROW_VALS; k++) begin
      v = int'(a) * 37 + k * 11 + 5;
      r[k] = v[data_len-1:0];
    end
    return r;
  endfunction

endpackage

//--- common/weight_fetch_if.sv
`timescale 1ns/1ps

interface weight_fetch_if;
  import nn_pkg::*;

  logic req;
  layer_t layer;
  phase_t phase;
  logic ack;
  wvec_t weights;  // valid while ack is high.

  modport requester (
    output req, layer, phase,
    input ack, weights
  );

  modport store (
    input req, layer, phase,
    output ack, weights
  );

endinterface

//--- logic/dot_accumulator.sv
`timescale 1ns/1ps

module dot_accumulator (
  input logic clk,
  input logic rst_n,
  input nn_pkg::row_t sample,
  input nn_pkg::wvec_t weights,
  input nn_pkg::layer_t layer,
  input logic accum_en,
  input logic clear_en,
  input logic layer_done,
  output nn_pkg::acc_t result,
  output nn_pkg::layer_t result_layer,
  output logic result_valid
);
  import nn_pkg::*;

  acc_t sum;
  acc_t acc;

  // each of the four rows is matched against the same nine sample values.
  always_comb begin
    sum = '0;
    for (int i = 0; i < FETCH_VALS; i++) begin
      sum = sum + acc_t'(weights[i]) * acc_t'(sample[i % ROW_VALS]);
    end
  end

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      acc <= '0;
      result_valid <= 1'b0;
    end else begin
      if (accum_en) acc <= clear_en ? sum : acc + sum;  // first phase starts a new layer.
      result_valid <= layer_done;
    end
  end

  always_ff @(posedge clk) begin
    if (layer_done) begin
      result <= acc;
      result_layer <= layer;
    end
  end

endmodule

//--- logic/layer_sequencer.sv
`timescale 1ns/1ps

module layer_sequencer (
  input logic clk,
  input logic rst_n,
  input logic start,
  output logic done,
  weight_fetch_if.requester fetch,
  input nn_pkg::phase_t phase,
  input logic last,
  output logic phase_clear,
  output logic phase_step,
  output logic accum_en,
  output logic clear_en,
  output logic layer_done
);
  import nn_pkg::*;

  typedef enum logic [2:0] {IDLE, REQUEST, RELEASE, NEXT, FINISH} state_t;

  state_t state;
  layer_t layer;

  assign fetch.layer = layer;
  assign fetch.phase = phase;

  // the weights are valid on the edge that sees ack, so they are consumed there.
  assign accum_en = (state == REQUEST) && fetch.ack;
  assign clear_en = accum_en && (phase == '0);
  assign layer_done = (state == NEXT) && last;
  assign phase_step = (state == NEXT) && !last;
  assign phase_clear = (state == IDLE) || layer_done;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      state <= IDLE;
      layer <= LAYER0;
      fetch.req <= 1'b0;
      done <= 1'b0;
    end else begin
      case (state)
        IDLE: begin
          if (start) begin
            layer <= LAYER0;
            fetch.req <= 1'b1;
            state <= REQUEST;
          end
        end
        REQUEST: begin
          if (fetch.ack) begin
            fetch.req <= 1'b0;
            state <= RELEASE;
          end
        end
        RELEASE: begin
          if (!fetch.ack) state <= NEXT;  // store is ready for another fetch.
        end
        NEXT: begin
          if (!last) begin
            fetch.req <= 1'b1;
            state <= REQUEST;
          end else if (layer == AFFINE) begin
            done <= 1'b1;
            state <= FINISH;
          end else begin
            layer <= layer_t'(layer + 3'd1);
            fetch.req <= 1'b1;
            state <= REQUEST;
          end
        end
        FINISH: begin
          if (!start) begin
            done <= 1'b0;
            state <= IDLE;
          end
        end
        default: state <= IDLE;
      endcase
    end
  end

endmodule

//--- logic/phase_counter.sv
`timescale 1ns/1ps

module phase_counter #(
  parameter int NUM_PHASES = 8
) (
  input logic clk,
  input logic rst_n,
  input logic clear,
  input logic step,
  output nn_pkg::phase_t phase,
  output logic last
);
  import nn_pkg::*;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      phase <= '0;
    end else if (clear) begin
      phase <= '0;  // clear wins over step.
    end else if (step) begin
      phase <= phase + phase_t'(1);
    end
  end

  assign last = (phase == phase_t'(NUM_PHASES - 1));

endmodule

//--- logic/weight_fetch_top.sv
`timescale 1ns/1ps

module weight_fetch_top #(
  parameter int NUM_PHASES = 8
) (
  input logic clk,
  input logic rst_n,
  input logic start,
  input nn_pkg::row_t sample,
  output logic done,
  output nn_pkg::acc_t result,
  output nn_pkg::layer_t result_layer,
  output logic result_valid
);
  import nn_pkg::*;

  phase_t phase;
  logic last;
  logic phase_clear;
  logic phase_step;
  logic accum_en;
  logic clear_en;
  logic layer_done;

  weight_fetch_if fetch_if ();

  layer_sequencer i_seq (
    .clk(clk),
    .rst_n(rst_n),
    .start(start),
    .done(done),
    .fetch(fetch_if.requester),
    .phase(phase),
    .last(last),
    .phase_clear(phase_clear),
    .phase_step(phase_step),
    .accum_en(accum_en),
    .clear_en(clear_en),
    .layer_done(layer_done)
  );

  phase_counter #(
    .NUM_PHASES(NUM_PHASES)
  ) i_phase (
    .clk(clk),
    .rst_n(rst_n),
    .clear(phase_clear),
    .step(phase_step),
    .phase(phase),
    .last(last)
  );

  weight_store #(
    .NUM_PHASES(NUM_PHASES)
  ) i_store (
    .clk(clk),
    .rst_n(rst_n),
    .fetch(fetch_if.store)
  );

  dot_accumulator i_acc (
    .clk(clk),
    .rst_n(rst_n),
    .sample(sample),
    .weights(fetch_if.weights),
    .layer(fetch_if.layer),
    .accum_en(accum_en),
    .clear_en(clear_en),
    .layer_done(layer_done),
    .result(result),
    .result_layer(result_layer),
    .result_valid(result_valid)
  );

endmodule

//--- run_sim.sh
#!/usr/bin/env bash
# Compile and run the weight fetch testbench with Verilator.

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f build.f --top-module tb_weight_fetch -o sim_tb
if [ $? -ne 0 ]; then
  echo "compile failed"
  exit 1
fi

./obj_dir/sim_tb
status=$?
if [ $status -ne 0 ]; then
  echo "simulation failed with status $status"
  exit $status
fi

echo "simulation finished"
exit 0

//--- weight_store/weight_rom.sv
`timescale 1ns/1ps

module weight_rom #(
  parameter int NUM_PHASES = 8
) (
  input logic clk,
  input nn_pkg::rom_addr_t addr,
  output nn_pkg::row_t q
);
  import nn_pkg::*;

  localparam int ROWS_USED = NUM_PHASES * ROWS_PER_FETCH;
  localparam int DEPTH = NUM_LAYERS * ROWS_USED;

  row_t mem [DEPTH];
  int unsigned mem_idx;

  // only the rows a layer actually uses are kept, so the layer stride is folded out.
  initial begin
    for (int l = 0; l < NUM_LAYERS; l++) begin
      for (int r = 0; r < ROWS_USED; r++) begin
        mem[l * ROWS_USED + r] = rom_row(rom_addr_t'(l * ROWS_PER_LAYER + r));
      end
    end
  end

  assign mem_idx = (int'(addr) / ROWS_PER_LAYER) * ROWS_USED + int'(addr) % ROWS_PER_LAYER;

  always_ff @(posedge clk) begin
    q <= mem[mem_idx];
  end

endmodule

//--- weight_store/weight_store.sv
`timescale 1ns/1ps

module weight_store #(
  parameter int NUM_PHASES = 8
) (
  input logic clk,
  input logic rst_n,
  weight_fetch_if.store fetch
);
  import nn_pkg::*;

  rom_addr_t rom_addr;
  rom_addr_t base_addr;
  row_t rom_q;
  logic busy;
  logic start_fetch;
  logic [2:0] cnt;       // edges spent in the current fetch.
  logic [1:0] row_slot;  // which quarter of the weight vector the next row fills.

  weight_rom #(
    .NUM_PHASES(NUM_PHASES)
  ) i_rom (
    .clk(clk),
    .addr(rom_addr),
    .q(rom_q)
  );

  assign base_addr = rom_addr_t'(int'(fetch.layer) * ROWS_PER_LAYER +
                                 int'(fetch.phase) * ROWS_PER_FETCH);

  // a fetch only starts once the previous ack has been released.
  assign start_fetch = !busy && fetch.req && !fetch.ack;

  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      busy <= 1'b0;
      cnt <= '0;
      row_slot <= '0;
      fetch.ack <= 1'b0;
    end else if (!busy) begin
      if (start_fetch) begin
        busy <= 1'b1;
        cnt <= '0;
        row_slot <= '0;
      end
      if (!fetch.req) fetch.ack <= 1'b0;
    end else begin
      cnt <= cnt + 3'd1;
      if (cnt != 3'd0) row_slot <= row_slot + 2'd1;
      if (cnt == 3'd4) begin
        busy <= 1'b0;
        fetch.ack <= 1'b1;  // the fourth row lands on this edge.
      end
    end
  end

  // rows come back one cycle after their address, so storing starts at cnt 1.
  always_ff @(posedge clk) begin
    if (start_fetch) begin
      rom_addr <= base_addr;
    end else if (busy && cnt < 3'd3) begin
      rom_addr <= rom_addr + rom_addr_t'(1);
    end
    if (busy && cnt != 3'd0) begin
      fetch.weights[int'(row_slot) * ROW_VALS +: ROW_VALS] <= rom_q;
    end
  end

endmodule
